//--- sim.f
+incdir+.
pkt_test_pkg.sv
pkt_gen.sv
pkt_len_fifo.sv
pkt_chk.sv
frame_counters.sv
pkt_test_top.sv
pkt_test_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= pkt_test_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the simulation output
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

//--- pkt_test_tb.sv
/* Loopback testbench for pkt_test_top. At most one packet is in flight, so the
   expected header and pattern follow the last request made by the stimulus. */

`include "pkt_test_config.svh"

module pkt_test_tb;

    localparam int wait_limit = 2000;

    logic                       phys_port_clk_ifc;
    logic                       rst;
    logic                       send_req;
    pkt_test_pkg::pkt_len_t     send_len;
    logic                       busy;
    logic [`PKT_DATA_WIDTH-1:0] tx_tdata;
    logic                       tx_tvalid;
    logic                       tx_tlast;
    logic                       tx_tready;
    logic [`PKT_DATA_WIDTH-1:0] rx_tdata;
    logic                       rx_tvalid;
    logic                       rx_tlast;
    logic                       rx_tready;
    logic                       cnt_clear;
    pkt_test_pkg::pkt_cnt_t     tx_frames;
    pkt_test_pkg::pkt_cnt_t     rx_frames;
    pkt_test_pkg::pkt_cnt_t     rx_errors;
    logic                       len_err;
    logic                       seq_err;
    logic                       data_err;

    integer                     seed = 32'h4063ccc4;
    logic                       stall;
    logic                       corrupt_pkt;
    logic                       err_allowed;
    logic                       chk_stb;
    pkt_test_pkg::pkt_cnt_t     exp_tx;
    pkt_test_pkg::pkt_cnt_t     exp_rx;
    pkt_test_pkg::pkt_cnt_t     exp_err;
    pkt_test_pkg::pkt_len_t     cur_len;
    pkt_test_pkg::pkt_len_t     last_idx;
    logic [15:0]                beat_idx;
    pkt_test_pkg::pkt_seq_t     exp_seq;
    pkt_test_pkg::pkt_word_u    rx_word;
    logic [`PKT_DATA_WIDTH-1:0] exp_pay;
    logic                       tx_hs;
    logic                       rx_hs;
    int                         check_errors;
    int                         base_errors;
    int                         tests_run;
    int                         tests_failed;
    logic                       timed_out;
    int                         r;

    pkt_test_top u_pkt_test_top (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .send_req          ( send_req          ),
        .send_len          ( send_len          ),
        .busy              ( busy              ),
        .tx_tdata          ( tx_tdata          ),
        .tx_tvalid         ( tx_tvalid         ),
        .tx_tlast          ( tx_tlast          ),
        .tx_tready         ( tx_tready         ),
        .rx_tdata          ( rx_tdata          ),
        .rx_tvalid         ( rx_tvalid         ),
        .rx_tlast          ( rx_tlast          ),
        .rx_tready         ( rx_tready         ),
        .cnt_clear         ( cnt_clear         ),
        .tx_frames         ( tx_frames         ),
        .rx_frames         ( rx_frames         ),
        .rx_errors         ( rx_errors         ),
        .len_err           ( len_err           ),
        .seq_err           ( seq_err           ),
        .data_err          ( data_err          )
    );

    initial begin
        phys_port_clk_ifc = 1'b0;
        forever #20 phys_port_clk_ifc = ~phys_port_clk_ifc;
    end

    //////////////////////////////
    // Loopback with stalls and byte corruption

    // Byte 0 of the first payload beat is flipped on a corrupted packet
    assign rx_tdata  = tx_tdata ^ ((corrupt_pkt && beat_idx == 16'd1) ? 32'h0000_005a : 32'h0);
    assign rx_tvalid = tx_tvalid && !stall;
    assign rx_tlast  = tx_tlast;
    assign tx_tready = rx_tready && !stall;
    assign tx_hs     = tx_tvalid && tx_tready;
    assign rx_hs     = rx_tvalid && rx_tready;
    assign rx_word   = rx_tdata;
    assign exp_pay   = pattern_word(cur_len, beat_idx);
    assign last_idx  = cur_len / 16'(`PKT_DATA_BYTES)
        + ((cur_len % 16'(`PKT_DATA_BYTES)) != '0 ? 16'd1 : 16'd0);

    always @(posedge phys_port_clk_ifc) begin
        #1;
        stall = ($random(seed) % 4) == 0;
    end

    // Beat position and expected seq of the packet on the wire
    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            beat_idx    <= '0;
            exp_seq     <= '0;
            err_allowed <= 1'b0;
        end else begin
            err_allowed <= tx_hs && tx_tlast && corrupt_pkt;
            if (tx_hs && tx_tlast) begin
                beat_idx <= '0;
                exp_seq  <= exp_seq + 1'b1;
            end else if (tx_hs) begin
                beat_idx <= beat_idx + 16'd1;
            end
        end
    end

    // Byte i of the payload is i mod 256, zero past the length
    function automatic logic [`PKT_DATA_WIDTH-1:0] pattern_word(
        input pkt_test_pkg::pkt_len_t len,
        input logic [15:0]            beat
    );
        pkt_test_pkg::pkt_word_u w;
        int                      idx;
        w = '0;
        for (int k = 0; k < `PKT_DATA_BYTES; k++) begin
            idx = (int'(beat) - 1) * `PKT_DATA_BYTES + k;
            if (idx < int'(len)) begin
                w.bytes[k] = 8'(idx % 256);
            end
        end
        return w;
    endfunction

    task automatic report_check(input string msg);
        check_errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    //////////////////////////////
    // Checks

    a_reset_idle: assert property (@(posedge phys_port_clk_ifc)
        $fell(rst) |-> !busy && !tx_tvalid && rx_tready && !len_err && !seq_err && !data_err
            && tx_frames == '0 && rx_frames == '0 && rx_errors == '0)
        else report_check("outputs not idle after reset");

    // Every header here has its record entry, so the checker never stalls
    a_rx_ready: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        rx_tvalid |-> rx_tready)
        else report_check("rx_tready low while a sent packet was waiting");

    a_hdr_fields: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        rx_hs && beat_idx == 16'd0 |-> rx_word.hdr.seq == exp_seq && rx_word.hdr.len == cur_len)
        else report_check("header seq or len wrong");

    a_payload: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        tx_hs && beat_idx != 16'd0 |-> tx_tdata == exp_pay)
        else report_check("payload beat off pattern");

    a_tlast_pos: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        tx_hs |-> tx_tlast == (beat_idx == last_idx))
        else report_check("tlast on wrong beat");

    a_busy_falls: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        tx_hs && tx_tlast |=> !busy)
        else report_check("busy still high after tlast");

    a_no_len_seq_err: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        !(len_err || seq_err))
        else report_check("unexpected len_err or seq_err");

    a_data_err_only: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        data_err |-> err_allowed)
        else report_check("data_err on a clean packet");

    a_data_err_seen: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        err_allowed |-> data_err)
        else report_check("no data_err on corrupted packet");

    a_counts: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        chk_stb |-> tx_frames == exp_tx && rx_frames == exp_rx && rx_errors == exp_err)
        else report_check($sformatf("counters %0d %0d %0d, expected %0d %0d %0d",
            tx_frames, rx_frames, rx_errors, exp_tx, exp_rx, exp_err));

    a_clear: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        cnt_clear |=> tx_frames == '0 && rx_frames == '0 && rx_errors == '0)
        else report_check("counters not zero after clear");

    //////////////////////////////
    // Stimulus tasks

    task automatic wait_not_busy(input string what);
        int waited;
        waited = 0;
        while (busy && waited < wait_limit) begin
            @(posedge phys_port_clk_ifc);
            #2;
            waited++;
        end
        if (busy) begin
            $display("Timeout: busy stayed high %0d cycles %s", wait_limit, what);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_packet(input int len);
        if (!timed_out) begin
            wait_not_busy("before a request");
        end
        if (!timed_out) begin
            cur_len  = pkt_test_pkg::pkt_len_t'(len);
            send_len = pkt_test_pkg::pkt_len_t'(len);
            send_req = 1'b1;
            @(posedge phys_port_clk_ifc);
            #2;
            send_req = 1'b0;
            wait_not_busy("while a packet was sent");
        end
    endtask

    task automatic check_counts(input int tx, input int rx, input int err);
        @(posedge phys_port_clk_ifc);
        #2;
        exp_tx  = pkt_test_pkg::pkt_cnt_t'(tx);
        exp_rx  = pkt_test_pkg::pkt_cnt_t'(rx);
        exp_err = pkt_test_pkg::pkt_cnt_t'(err);
        chk_stb = 1'b1;
        @(posedge phys_port_clk_ifc);
        #2;
        chk_stb = 1'b0;
    endtask

    task automatic clear_counters();
        @(posedge phys_port_clk_ifc);
        #2;
        cnt_clear = 1'b1;
        @(posedge phys_port_clk_ifc);
        #2;
        cnt_clear = 1'b0;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (check_errors != base_errors || timed_out) begin
            tests_failed++;
            $display("test %0d %s: %0d check errors", tests_run, name, check_errors - base_errors);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        base_errors = check_errors;
    endtask

    //////////////////////////////
    // Test sequence

    initial begin
        rst = 1'b1;
        send_req = 1'b0;
        send_len = '0;
        cnt_clear = 1'b0;
        stall = 1'b0;
        corrupt_pkt = 1'b0;
        chk_stb = 1'b0;
        exp_tx = '0;
        exp_rx = '0;
        exp_err = '0;
        cur_len = '0;
        check_errors = 0;
        base_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        repeat (16) @(posedge phys_port_clk_ifc);
        #2;
        rst = 1'b0;

        check_counts(0, 0, 0);
        finish_test("reset state");

        send_packet(7);
        check_counts(1, 1, 0);
        finish_test("single 7-byte packet");

        clear_counters();
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            send_packet(1 + (r & 32'h7fff_ffff) % 100);
        end
        check_counts(40, 40, 0);
        finish_test("40 random packets with stalls");

        send_packet(13);
        send_packet(64);
        corrupt_pkt = 1'b1;
        send_packet(29);
        corrupt_pkt = 1'b0;
        send_packet(5);
        send_packet(100);
        send_packet(1);
        check_counts(46, 46, 1);
        finish_test("corrupted payload byte");

        clear_counters();
        check_counts(0, 0, 0);
        send_packet(11);
        check_counts(1, 1, 0);
        finish_test("counter clear");

        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, check_errors);
        if (timed_out || check_errors != 0) begin
            $display("*** FAILED ***");
        end else begin
            $display("*** PASSED ***");
        end
        $finish;
    end

endmodule

//--- pkt_test_top.sv
/* Single-port packet test engine on phys_port_clk_ifc. The rx stream must
   return tx packets in order; at most PKT_FIFO_DEPTH may be in flight. */

`include "pkt_test_config.svh"

module pkt_test_top (
    input  logic                       phys_port_clk_ifc,
    input  logic                       rst,
    input  logic                       send_req,
    input  pkt_test_pkg::pkt_len_t     send_len,
    output logic                       busy,
    output logic [`PKT_DATA_WIDTH-1:0] tx_tdata,
    output logic                       tx_tvalid,
    output logic                       tx_tlast,
    input  logic                       tx_tready,
    input  logic [`PKT_DATA_WIDTH-1:0] rx_tdata,
    input  logic                       rx_tvalid,
    input  logic                       rx_tlast,
    output logic                       rx_tready,
    input  logic                       cnt_clear,
    output pkt_test_pkg::pkt_cnt_t     tx_frames,
    output pkt_test_pkg::pkt_cnt_t     rx_frames,
    output pkt_test_pkg::pkt_cnt_t     rx_errors,
    output logic                       len_err,
    output logic                       seq_err,
    output logic                       data_err
);

    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   len_push;
    pkt_test_pkg::pkt_len_t len_push_data;
    logic                   len_pop;
    pkt_test_pkg::pkt_len_t front_len;
    logic                   tx_frame;
    logic                   rx_frame;
    logic                   rx_error;

    //////////////////////////////
    // Transmit side

    pkt_gen u_pkt_gen (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .send_req          ( send_req          ),
        .send_len          ( send_len          ),
        .fifo_full         ( fifo_full         ),
        .busy              ( busy              ),
        .len_push          ( len_push          ),
        .len_push_data     ( len_push_data     ),
        .tx_tdata          ( tx_tdata          ),
        .tx_tvalid         ( tx_tvalid         ),
        .tx_tlast          ( tx_tlast          ),
        .tx_tready         ( tx_tready         )
    );

    pkt_len_fifo u_pkt_len_fifo (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .push              ( len_push          ),
        .push_len          ( len_push_data     ),
        .pop               ( len_pop           ),
        .front_len         ( front_len         ),
        .empty             ( fifo_empty        ),
        .full              ( fifo_full         )
    );

    //////////////////////////////
    // Receive side

    pkt_chk u_pkt_chk (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .rx_tdata          ( rx_tdata          ),
        .rx_tvalid         ( rx_tvalid         ),
        .rx_tlast          ( rx_tlast          ),
        .rx_tready         ( rx_tready         ),
        .exp_len           ( front_len         ),
        .exp_empty         ( fifo_empty        ),
        .len_pop           ( len_pop           ),
        .len_err           ( len_err           ),
        .seq_err           ( seq_err           ),
        .data_err          ( data_err          )
    );

    // Frame ends on a tlast handshake
    assign tx_frame = tx_tvalid && tx_tready && tx_tlast;
    assign rx_frame = rx_tvalid && rx_tready && rx_tlast;
    assign rx_error = len_err || seq_err || data_err;

    frame_counters u_frame_counters (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .cnt_clear         ( cnt_clear         ),
        .tx_frame          ( tx_frame          ),
        .rx_frame          ( rx_frame          ),
        .rx_error          ( rx_error          ),
        .tx_frames         ( tx_frames         ),
        .rx_frames         ( rx_frames         ),
        .rx_errors         ( rx_errors         )
    );

endmodule

//--- frame_counters.sv
/* Saturating frame and error counters. A clear wins over a count in the
   same cycle. */

module frame_counters (
    input  logic                   phys_port_clk_ifc,
    input  logic                   rst,
    input  logic                   cnt_clear,
    input  logic                   tx_frame,
    input  logic                   rx_frame,
    input  logic                   rx_error,
    output pkt_test_pkg::pkt_cnt_t tx_frames,
    output pkt_test_pkg::pkt_cnt_t rx_frames,
    output pkt_test_pkg::pkt_cnt_t rx_errors
);

    localparam int num_cnt = 3;

    logic [num_cnt-1:0]     inc;
    pkt_test_pkg::pkt_cnt_t cnt [num_cnt];

    // Index 0 tx frames, 1 rx frames, 2 rx errors
    assign inc = {rx_error, rx_frame, tx_frame};

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst || cnt_clear) begin
            for (int i = 0; i < num_cnt; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_cnt; i++) begin
                // Stick at all ones
                if (inc[i] && (cnt[i] != '1)) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign tx_frames = cnt[0];
    assign rx_frames = cnt[1];
    assign rx_errors = cnt[2];

endmodule

//--- pkt_chk.sv
/* Checks returning packets against the length record and the incrementing
   pattern. Fault pulses follow the tlast beat by one cycle, one per kind. */

`include "pkt_test_config.svh"

module pkt_chk (
    input  logic                       phys_port_clk_ifc,
    input  logic                       rst,
    input  logic [`PKT_DATA_WIDTH-1:0] rx_tdata,
    input  logic                       rx_tvalid,
    input  logic                       rx_tlast,
    output logic                       rx_tready,
    input  pkt_test_pkg::pkt_len_t     exp_len,
    input  logic                       exp_empty,
    output logic                       len_pop,
    output logic                       len_err,
    output logic                       seq_err,
    output logic                       data_err
);

    localparam pkt_test_pkg::pkt_len_t beat_bytes = `PKT_DATA_BYTES;
    localparam pkt_test_pkg::pkt_len_t one        = 1;

    logic                    in_hdr;
    pkt_test_pkg::pkt_seq_t  exp_seq;
    pkt_test_pkg::pkt_len_t  pkt_len;
    pkt_test_pkg::pkt_len_t  off;
    pkt_test_pkg::pkt_len_t  beats_left;
    logic                    len_f;
    logic                    seq_f;
    logic                    data_f;
    pkt_test_pkg::pkt_word_u rx_word;
    pkt_test_pkg::pkt_word_u exp_word;
    logic                    rx_beat;
    logic                    beat_len_bad;
    logic                    beat_seq_bad;
    logic                    beat_data_bad;

    assign rx_word = rx_tdata;

    // Hold off a header that has no record entry yet
    assign rx_tready = !(in_hdr && exp_empty && rx_tvalid);
    assign rx_beat   = rx_tvalid && rx_tready;
    assign len_pop   = rx_beat && in_hdr;

    // Pattern for the current payload beat
    always_comb begin
        exp_word = '0;
        for (int k = 0; k < `PKT_DATA_BYTES; k++) begin
            if (off + pkt_test_pkg::pkt_len_t'(k) < pkt_len) begin
                exp_word.bytes[k] = off[7:0] + 8'(k);
            end
        end
    end

    always_comb begin
        if (in_hdr) begin
            // A header alone is too short
            beat_len_bad  = (rx_word.hdr.len != exp_len) || rx_tlast;
            beat_seq_bad  = rx_word.hdr.seq != exp_seq;
            beat_data_bad = 1'b0;
        end else begin
            // Early tlast, or tlast missing on the last expected beat
            beat_len_bad  = rx_tlast ? (beats_left != one) : (beats_left <= one);
            beat_seq_bad  = 1'b0;
            beat_data_bad = rx_word != exp_word;
        end
    end

    //////////////////////////////
    // Packet state and faults

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            in_hdr   <= 1'b1;
            exp_seq  <= '0;
            len_f    <= 1'b0;
            seq_f    <= 1'b0;
            data_f   <= 1'b0;
            len_err  <= 1'b0;
            seq_err  <= 1'b0;
            data_err <= 1'b0;
        end else begin
            len_err  <= 1'b0;
            seq_err  <= 1'b0;
            data_err <= 1'b0;
            if (rx_beat && rx_tlast) begin
                in_hdr   <= 1'b1;
                len_err  <= len_f || beat_len_bad;
                seq_err  <= seq_f || beat_seq_bad;
                data_err <= data_f || beat_data_bad;
                len_f    <= 1'b0;
                seq_f    <= 1'b0;
                data_f   <= 1'b0;
            end else if (rx_beat) begin
                in_hdr <= 1'b0;
                len_f  <= len_f || beat_len_bad;
                seq_f  <= seq_f || beat_seq_bad;
                data_f <= data_f || beat_data_bad;
            end
            if (len_pop) begin
                exp_seq <= exp_seq + 1'b1;
            end
        end
    end

    // Position within the packet, loaded from the record at the header
    always_ff @(posedge phys_port_clk_ifc) begin
        if (len_pop) begin
            pkt_len    <= exp_len;
            off        <= '0;
            beats_left <= (exp_len + beat_bytes - one) / beat_bytes;
        end else if (rx_beat) begin
            off <= off + beat_bytes;
            if (beats_left != '0) begin
                beats_left <= beats_left - one;
            end
        end
    end

endmodule

//--- pkt_len_fifo.sv
/* Lengths of sent packets in send order. Front entry is valid only while
   empty is low; pushes when full and pops when empty are dropped. */

`include "pkt_test_config.svh"

module pkt_len_fifo (
    input  logic                   phys_port_clk_ifc,
    input  logic                   rst,
    input  logic                   push,
    input  pkt_test_pkg::pkt_len_t push_len,
    input  logic                   pop,
    output pkt_test_pkg::pkt_len_t front_len,
    output logic                   empty,
    output logic                   full
);

    localparam int depth    = `PKT_FIFO_DEPTH;
    localparam int ptr_bits = $clog2(depth);
    localparam int cnt_bits = $clog2(depth + 1);

    pkt_test_pkg::pkt_len_t mem [depth];
    logic [ptr_bits-1:0]    wr_ptr;
    logic [ptr_bits-1:0]    rd_ptr;
    logic [cnt_bits-1:0]    count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty     = count == '0;
    assign full      = count == cnt_bits'(depth);
    assign front_len = mem[rd_ptr];

    always_ff @(posedge phys_port_clk_ifc) begin
        if (do_push) begin
            mem[wr_ptr] <= push_len;
        end
    end

    // Pointers wrap at depth, which need not be a power of two
    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        push |-> !full);

    a_no_underflow: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        pop |-> !empty);

endmodule

//--- pkt_gen.sv
/* Sends one header beat and then ceil(len/4) payload beats per request.
   Requests with a length of 0 or above the MTU are not supported. */

`include "pkt_test_config.svh"

module pkt_gen (
    input  logic                       phys_port_clk_ifc,
    input  logic                       rst,
    input  logic                       send_req,
    input  pkt_test_pkg::pkt_len_t     send_len,
    input  logic                       fifo_full,
    output logic                       busy,
    output logic                       len_push,
    output pkt_test_pkg::pkt_len_t     len_push_data,
    output logic [`PKT_DATA_WIDTH-1:0] tx_tdata,
    output logic                       tx_tvalid,
    output logic                       tx_tlast,
    input  logic                       tx_tready
);

    localparam logic [1:0] s_idle = 2'd0;
    localparam logic [1:0] s_hdr  = 2'd1;
    localparam logic [1:0] s_pay  = 2'd2;

    localparam pkt_test_pkg::pkt_len_t beat_bytes = `PKT_DATA_BYTES;
    localparam pkt_test_pkg::pkt_len_t mtu_bytes  = `PKT_MTU_BYTES;

    logic [1:0]                state;
    pkt_test_pkg::pkt_seq_t    seq;
    pkt_test_pkg::pkt_len_t    off;
    pkt_test_pkg::pkt_len_t    rem_len;
    pkt_test_pkg::pkt_word_u   hdr_word;
    pkt_test_pkg::pkt_word_u   next_word;
    logic                      next_last;
    logic                      take_req;
    logic                      beat_done;

    // Full record also holds off new requests
    assign busy      = (state != s_idle) || fifo_full;
    assign take_req  = send_req && !busy;
    assign beat_done = tx_tvalid && tx_tready;

    assign len_push      = take_req;
    assign len_push_data = send_len;

    always_comb begin
        hdr_word         = '0;
        hdr_word.hdr.seq = seq;
        hdr_word.hdr.len = send_len;
    end

    // Next payload beat, zero past the end of the packet
    always_comb begin
        next_word = '0;
        for (int k = 0; k < `PKT_DATA_BYTES; k++) begin
            if (pkt_test_pkg::pkt_len_t'(k) < rem_len) begin
                next_word.bytes[k] = off[7:0] + 8'(k);
            end
        end
    end

    assign next_last = rem_len <= beat_bytes;

    //////////////////////////////
    // FSM

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            state     <= s_idle;
            seq       <= '0;
            tx_tvalid <= 1'b0;
            tx_tlast  <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (take_req) begin
                        state     <= s_hdr;
                        seq       <= seq + 1'b1;
                        tx_tvalid <= 1'b1;
                        tx_tlast  <= 1'b0;
                    end
                end
                s_hdr: begin
                    if (beat_done) begin
                        state    <= s_pay;
                        tx_tlast <= next_last;
                    end
                end
                s_pay: begin
                    if (beat_done && tx_tlast) begin
                        state     <= s_idle;
                        tx_tvalid <= 1'b0;
                        tx_tlast  <= 1'b0;
                    end else if (beat_done) begin
                        tx_tlast <= next_last;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Beat data and position
    always_ff @(posedge phys_port_clk_ifc) begin
        if (take_req) begin
            tx_tdata <= hdr_word;
            off      <= '0;
            rem_len  <= send_len;
        end else if (beat_done && !tx_tlast) begin
            tx_tdata <= next_word;
            off      <= off + beat_bytes;
            rem_len  <= rem_len - beat_bytes;
        end
    end

    a_stall_hold: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast));

    a_req_len: assert property (@(posedge phys_port_clk_ifc) disable iff (rst)
        take_req |-> send_len != '0 && send_len <= mtu_bytes);

endmodule

//--- pkt_test_pkg.sv
/* Types shared by the generator and checker. Header fields must fill one
   stream beat exactly, so PKT_SEQ_WIDTH + PKT_LEN_WIDTH = PKT_DATA_WIDTH. */

`include "pkt_test_config.svh"

package pkt_test_pkg;

    //////////////////////////////
    // Scalar types

    // Packet length in bytes, header excluded
    typedef logic [`PKT_LEN_WIDTH-1:0] pkt_len_t;

    typedef logic [`PKT_SEQ_WIDTH-1:0] pkt_seq_t;

    // Frame and error counts
    typedef logic [`PKT_CNT_WIDTH-1:0] pkt_cnt_t;

    //////////////////////////////
    // Beat layouts

    // First beat of a packet
    typedef struct packed {
        pkt_seq_t seq;
        pkt_len_t len;
    } pkt_hdr_t;

    // Header view on beat 0, byte view on payload beats
    typedef union packed {
        pkt_hdr_t                             hdr;
        logic [`PKT_DATA_BYTES-1:0][7:0] bytes;
    } pkt_word_u;

endpackage

//--- pkt_test_config.svh
/* Sizes for the packet test engine. Only a 4-byte stream beat is supported,
   and lengths above PKT_MTU_BYTES are not generated or checked. */

`ifndef PKT_TEST_CONFIG_SVH
`define PKT_TEST_CONFIG_SVH

//////////////////////////////
// Stream beat

// Bytes carried by one beat
`define PKT_DATA_BYTES 4

// Must equal 8 * PKT_DATA_BYTES
`define PKT_DATA_WIDTH 32

//////////////////////////////
// Packet fields

// Largest packet byte length
`define PKT_MTU_BYTES 1500

// Header length and sequence fields
`define PKT_LEN_WIDTH 16
`define PKT_SEQ_WIDTH 16

//////////////////////////////
// Tracking

// Packets in flight between generator and checker
`define PKT_FIFO_DEPTH 16

// Frame and error counters
`define PKT_CNT_WIDTH 32

`endif
